// ==== source/ex_pkg.sv ====
package ex_pkg;

	////////////////////
	// widths
	////////////////////
	localparam int data_width     = 32;
	localparam int reg_addr_width = 5;
	localparam int shamt_width    = 5;
	localparam int div_steps      = 32;

	////////////////////
	// decode encodings
	////////////////////

	// operation group from decode
	typedef enum logic [2:0] {
		sel_nop   = 3'b000,
		sel_logic = 3'b001,
		sel_shift = 3'b010,
		sel_move  = 3'b011,
		sel_arith = 3'b100
	} alusel_t;

	// operation code, shares values with the function field where it can
	typedef enum logic [7:0] {
		op_sll   = 8'h00,
		op_srl   = 8'h02,
		op_sra   = 8'h03,
		op_lui   = 8'h0f,
		op_mfhi  = 8'h10,
		op_mthi  = 8'h11,
		op_mflo  = 8'h12,
		op_mtlo  = 8'h13,
		op_mult  = 8'h18,
		op_multu = 8'h19,
		op_div   = 8'h1a,
		op_divu  = 8'h1b,
		op_add   = 8'h20,
		op_addu  = 8'h21,
		op_sub   = 8'h22,
		op_subu  = 8'h23,
		op_and   = 8'h24,
		op_or    = 8'h25,
		op_xor   = 8'h26,
		op_nor   = 8'h27,
		op_slt   = 8'h2a,
		op_sltu  = 8'h2b
	} aluop_t;

	typedef enum logic [1:0] {
		div_idle   = 2'b00,
		div_run    = 2'b01,
		div_finish = 2'b10
	} div_state_t;

	////////////////////
	// stage payloads
	////////////////////
	typedef struct packed {
		logic                      we;
		logic [reg_addr_width-1:0] waddr;
		logic [data_width-1:0]     wdata;
	} wb_payload_t;

	typedef struct packed {
		logic                  whilo;
		logic [data_width-1:0] hi;
		logic [data_width-1:0] lo;
	} hilo_payload_t;

endpackage

// ==== source/alu_comb.sv ====
module alu_comb (
	input  ex_pkg::alusel_t                   alusel,
	input  ex_pkg::aluop_t                    aluop,
	input  logic [ex_pkg::data_width-1:0]     reg1_data,
	input  logic [ex_pkg::data_width-1:0]     reg2_data,
	input  logic [ex_pkg::data_width-1:0]     hi_value,
	input  logic [ex_pkg::data_width-1:0]     lo_value,
	output logic [ex_pkg::data_width-1:0]     result,
	output logic                              overflow,
	output logic [2*ex_pkg::data_width-1:0]   product
);
	import ex_pkg::*;

	localparam int msb = data_width - 1;

	logic [shamt_width-1:0]  shamt;
	logic [data_width-1:0]   logic_out;
	logic [data_width-1:0]   shift_out;
	logic [data_width-1:0]   move_out;
	logic [data_width-1:0]   arith_out;
	logic                    is_sub;
	logic [data_width-1:0]   operand_b;
	logic [data_width-1:0]   sum;
	logic                    signed_mul;
	logic [data_width-1:0]   mag_a;
	logic [data_width-1:0]   mag_b;
	logic [2*data_width-1:0] mag_prod;
	logic                    prod_neg;

	// shift amount comes from the first operand, value from the second
	assign shamt = reg1_data[shamt_width-1:0];

	////////////////////
	// logic and shift
	////////////////////
	always_comb begin
		case (aluop)
			op_and:  logic_out = reg1_data & reg2_data;
			op_or:   logic_out = reg1_data | reg2_data;
			op_xor:  logic_out = reg1_data ^ reg2_data;
			op_nor:  logic_out = ~(reg1_data | reg2_data);
			op_lui:  logic_out = {reg2_data[15:0], 16'h0000};
			default: logic_out = '0;
		endcase
	end

	always_comb begin
		case (aluop)
			op_sll:  shift_out = reg2_data << shamt;
			op_srl:  shift_out = reg2_data >> shamt;
			// sign fill
			op_sra:  shift_out = $unsigned($signed(reg2_data) >>> shamt);
			default: shift_out = '0;
		endcase
	end

	// hilo reads, already bypassed by hilo_file
	always_comb begin
		case (aluop)
			op_mfhi: move_out = hi_value;
			op_mflo: move_out = lo_value;
			default: move_out = '0;
		endcase
	end

	////////////////////
	// add, sub, compare
	////////////////////
	assign is_sub    = (aluop == op_sub) || (aluop == op_subu);
	assign operand_b = is_sub ? ~reg2_data : reg2_data;
	assign sum       = reg1_data + operand_b + {{(data_width-1){1'b0}}, is_sub};

	// same operand signs but result sign flipped
	assign overflow = (alusel == sel_arith) && ((aluop == op_add) || (aluop == op_sub)) &&
		(reg1_data[msb] == operand_b[msb]) && (sum[msb] != reg1_data[msb]);

	always_comb begin
		case (aluop)
			op_add, op_addu, op_sub, op_subu: arith_out = sum;
			op_slt:  arith_out = {{msb{1'b0}}, $signed(reg1_data) < $signed(reg2_data)};
			op_sltu: arith_out = {{msb{1'b0}}, reg1_data < reg2_data};
			default: arith_out = '0;
		endcase
	end

	////////////////////
	// multiply
	////////////////////
	// magnitudes first, sign restored afterwards
	assign signed_mul = (aluop == op_mult);
	assign mag_a      = (signed_mul && reg1_data[msb]) ? -reg1_data : reg1_data;
	assign mag_b      = (signed_mul && reg2_data[msb]) ? -reg2_data : reg2_data;
	assign mag_prod   = {{data_width{1'b0}}, mag_a} * {{data_width{1'b0}}, mag_b};
	assign prod_neg   = signed_mul && (reg1_data[msb] ^ reg2_data[msb]);
	assign product    = prod_neg ? -mag_prod : mag_prod;

	// group select
	always_comb begin
		case (alusel)
			sel_nop:   result = '0;
			sel_logic: result = logic_out;
			sel_shift: result = shift_out;
			sel_move:  result = move_out;
			sel_arith: result = arith_out;
			default:   result = '0;
		endcase
	end

endmodule

// ==== source/div_ctrl.sv ====
module div_ctrl (
	input  logic             clk,
	input  logic             reset_n,
	input  ex_pkg::alusel_t  alusel,
	input  ex_pkg::aluop_t   aluop,
	input  logic             last_step,
	output logic             div_start,
	output logic             div_active,
	output logic             div_done,
	output logic             stall
);
	import ex_pkg::*;

	div_state_t state;
	div_state_t state_next;
	logic       div_req;

	assign div_req = (alusel == sel_arith) && ((aluop == op_div) || (aluop == op_divu));

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= div_idle;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			div_idle:   if (div_req) state_next = div_run;
			div_run:    if (last_step) state_next = div_finish;
			// one cycle to hand the result out
			div_finish: state_next = div_idle;
			default:    state_next = div_idle;
		endcase
	end

	// a request seen in finish is the held divide, not a new one
	assign div_start  = (state == div_idle) && div_req;
	assign div_active = (state == div_run);
	assign div_done   = (state == div_finish);
	assign stall      = (state == div_run);

endmodule

// ==== source/div_counter.sv ====
module div_counter #(
	parameter int step_count = 32
) (
	input  logic clk,
	input  logic reset_n,
	input  logic div_start,
	input  logic div_active,
	output logic last_step
);
	localparam int cnt_width = (step_count > 1) ? $clog2(step_count) : 1;

	logic [cnt_width-1:0] count;

	// start wins over counting
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			count <= '0;
		end else if (div_start) begin
			count <= '0;
		end else if (div_active) begin
			count <= count + 1'b1;
		end
	end

	// the step taken at the next edge is the final one
	assign last_step = div_active && (count == cnt_width'(step_count - 1));

endmodule

// ==== source/div_datapath.sv ====
module div_datapath (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          div_start,
	input  logic                          div_active,
	input  logic                          is_signed,
	input  logic [ex_pkg::data_width-1:0] dividend,
	input  logic [ex_pkg::data_width-1:0] divisor,
	output logic [ex_pkg::data_width-1:0] quotient,
	output logic [ex_pkg::data_width-1:0] remainder
);
	import ex_pkg::*;

	localparam int msb = data_width - 1;

	logic [data_width-1:0] dvs_mag;
	logic [data_width-1:0] rem_q;
	// holds the dividend magnitude, quotient bits shift in from the right
	logic [data_width-1:0] quo_q;
	logic                  quo_neg;
	logic                  rem_neg;
	logic [data_width-1:0] dvd_abs;
	logic [data_width-1:0] dvs_abs;
	logic [data_width:0]   shifted;
	logic [data_width:0]   trial;

	assign dvd_abs = (is_signed && dividend[msb]) ? -dividend : dividend;
	assign dvs_abs = (is_signed && divisor[msb]) ? -divisor : divisor;

	////////////////////
	// one restoring step
	////////////////////
	assign shifted = {rem_q, quo_q[msb]};
	assign trial   = shifted - {1'b0, dvs_mag};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			dvs_mag <= '0;
			rem_q   <= '0;
			quo_q   <= '0;
			quo_neg <= 1'b0;
			rem_neg <= 1'b0;
		end else if (div_start) begin
			dvs_mag <= dvs_abs;
			rem_q   <= '0;
			quo_q   <= dvd_abs;
			quo_neg <= is_signed && (dividend[msb] ^ divisor[msb]);
			rem_neg <= is_signed && dividend[msb];
		end else if (div_active) begin
			if (!trial[data_width]) begin
				// divisor fits, keep the difference
				rem_q <= trial[msb:0];
				quo_q <= {quo_q[msb-1:0], 1'b1};
			end else begin
				rem_q <= shifted[msb:0];
				quo_q <= {quo_q[msb-1:0], 1'b0};
			end
		end
	end

	////////////////////
	// sign fix-up
	////////////////////
	// quotient truncates toward zero, remainder follows the dividend
	assign quotient  = quo_neg ? -quo_q : quo_q;
	assign remainder = rem_neg ? -rem_q : rem_q;

endmodule

// ==== source/ex_stage_reg.sv ====
module ex_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset_n,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// a bubble is an all-zero payload, so no write enable is set
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			q <= '0;
		end else if (flush) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

endmodule

// ==== source/hilo_file.sv ====
module hilo_file (
	input  logic                          clk,
	input  logic                          reset_n,
	input  logic                          whilo,
	input  logic [ex_pkg::data_width-1:0] hi_in,
	input  logic [ex_pkg::data_width-1:0] lo_in,
	output logic [ex_pkg::data_width-1:0] hi_value,
	output logic [ex_pkg::data_width-1:0] lo_value
);
	import ex_pkg::*;

	logic [data_width-1:0] hi_q;
	logic [data_width-1:0] lo_q;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (whilo) begin
			hi_q <= hi_in;
			lo_q <= lo_in;
		end
	end

	// pending write from the stage register is newer than the stored pair
	assign hi_value = whilo ? hi_in : hi_q;
	assign lo_value = whilo ? lo_in : lo_q;

endmodule

// ==== source/ex_top.sv ====
module ex_top (
	input  logic                              clk,
	input  logic                              reset_n,
	input  ex_pkg::alusel_t                   alusel,
	input  ex_pkg::aluop_t                    aluop,
	input  logic [ex_pkg::data_width-1:0]     reg1_data,
	input  logic [ex_pkg::data_width-1:0]     reg2_data,
	input  logic                              id_we,
	input  logic [ex_pkg::reg_addr_width-1:0] id_waddr,
	output logic                              ex_we,
	output logic [ex_pkg::reg_addr_width-1:0] ex_waddr,
	output logic [ex_pkg::data_width-1:0]     ex_wdata,
	output logic                              ex_whilo,
	output logic [ex_pkg::data_width-1:0]     ex_hi,
	output logic [ex_pkg::data_width-1:0]     ex_lo,
	output logic                              stallreg_from_ex
);
	import ex_pkg::*;

	logic [data_width-1:0]   result;
	logic                    overflow;
	logic [2*data_width-1:0] product;
	logic [data_width-1:0]   hi_value;
	logic [data_width-1:0]   lo_value;
	logic                    div_start;
	logic                    div_active;
	logic                    div_done;
	logic                    last_step;
	logic [data_width-1:0]   quotient;
	logic [data_width-1:0]   remainder;
	wb_payload_t             wb_d;
	wb_payload_t             wb_q;
	hilo_payload_t           hilo_d;
	hilo_payload_t           hilo_q;

	alu_comb u_alu (
		.alusel    (alusel),
		.aluop     (aluop),
		.reg1_data (reg1_data),
		.reg2_data (reg2_data),
		.hi_value  (hi_value),
		.lo_value  (lo_value),
		.result    (result),
		.overflow  (overflow),
		.product   (product)
	);

	////////////////////
	// divider
	////////////////////
	div_ctrl u_div_ctrl (
		.clk        (clk),
		.reset_n    (reset_n),
		.alusel     (alusel),
		.aluop      (aluop),
		.last_step  (last_step),
		.div_start  (div_start),
		.div_active (div_active),
		.div_done   (div_done),
		.stall      (stallreg_from_ex)
	);

	div_counter #(
		.step_count (div_steps)
	) u_div_counter (
		.clk        (clk),
		.reset_n    (reset_n),
		.div_start  (div_start),
		.div_active (div_active),
		.last_step  (last_step)
	);

	div_datapath u_div_datapath (
		.clk        (clk),
		.reset_n    (reset_n),
		.div_start  (div_start),
		.div_active (div_active),
		.is_signed  (aluop == op_div),
		.dividend   (reg1_data),
		.divisor    (reg2_data),
		.quotient   (quotient),
		.remainder  (remainder)
	);

	////////////////////
	// payloads
	////////////////////
	// signed overflow suppresses the register write
	assign wb_d.we    = id_we && !overflow;
	assign wb_d.waddr = id_waddr;
	assign wb_d.wdata = result;

	always_comb begin
		hilo_d = '0;
		if (div_done) begin
			hilo_d.whilo = 1'b1;
			hilo_d.hi    = remainder;
			hilo_d.lo    = quotient;
		end else if (alusel == sel_arith && (aluop == op_mult || aluop == op_multu)) begin
			hilo_d.whilo = 1'b1;
			hilo_d.hi    = product[2*data_width-1:data_width];
			hilo_d.lo    = product[data_width-1:0];
		end else if (alusel == sel_move && aluop == op_mthi) begin
			// other half rewritten with its current value
			hilo_d.whilo = 1'b1;
			hilo_d.hi    = reg1_data;
			hilo_d.lo    = lo_value;
		end else if (alusel == sel_move && aluop == op_mtlo) begin
			hilo_d.whilo = 1'b1;
			hilo_d.hi    = hi_value;
			hilo_d.lo    = reg1_data;
		end
	end

	ex_stage_reg #(
		.payload_t (wb_payload_t)
	) u_wb_reg (
		.clk     (clk),
		.reset_n (reset_n),
		.flush   (stallreg_from_ex),
		.d       (wb_d),
		.q       (wb_q)
	);

	ex_stage_reg #(
		.payload_t (hilo_payload_t)
	) u_hilo_reg (
		.clk     (clk),
		.reset_n (reset_n),
		.flush   (stallreg_from_ex),
		.d       (hilo_d),
		.q       (hilo_q)
	);

	hilo_file u_hilo (
		.clk      (clk),
		.reset_n  (reset_n),
		.whilo    (hilo_q.whilo),
		.hi_in    (hilo_q.hi),
		.lo_in    (hilo_q.lo),
		.hi_value (hi_value),
		.lo_value (lo_value)
	);

	assign ex_we    = wb_q.we;
	assign ex_waddr = wb_q.waddr;
	assign ex_wdata = wb_q.wdata;
	assign ex_whilo = hilo_q.whilo;
	assign ex_hi    = hilo_q.hi;
	assign ex_lo    = hilo_q.lo;

endmodule

// ==== verification/ex_tb.sv ====
module ex_tb;
	import ex_pkg::*;

	localparam int clk_period   = 8;
	localparam int seed         = 45;
	localparam int reset_cycles = 4;
	localparam int n_logic      = 40;
	localparam int n_arith      = 40;
	localparam int n_mul        = 10;
	localparam int n_div        = 8;
	// directed cases and flushes on top of the random loops
	localparam int n_tests      = n_logic + n_arith + 5 * n_mul + n_div + 16;
	localparam int timeout      = (reset_cycles + n_tests * (div_steps + 2) + 100) * clk_period;

	localparam longint smax = 64'sd2147483647;
	localparam longint smin = -64'sd2147483648;

	logic                      clk = 1'b0;
	logic                      reset_n;
	alusel_t                   alusel;
	aluop_t                    aluop;
	logic [data_width-1:0]     reg1_data;
	logic [data_width-1:0]     reg2_data;
	logic                      id_we;
	logic [reg_addr_width-1:0] id_waddr;
	logic                      ex_we;
	logic [reg_addr_width-1:0] ex_waddr;
	logic [data_width-1:0]     ex_wdata;
	logic                      ex_whilo;
	logic [data_width-1:0]     ex_hi;
	logic [data_width-1:0]     ex_lo;
	logic                      stallreg_from_ex;

	// expectations seen by the assertions
	logic                      rst_chk;
	logic                      chk_stall;
	logic                      exp_stall;
	logic                      chk_wb;
	logic                      exp_we;
	logic [reg_addr_width-1:0] exp_waddr;
	logic [data_width-1:0]     exp_wdata;
	logic                      chk_hilo;
	logic                      exp_whilo;
	logic [data_width-1:0]     exp_hi;
	logic [data_width-1:0]     exp_lo;

	// prediction for the op just driven
	logic                      pend_wb_chk;
	logic                      pend_we;
	logic [reg_addr_width-1:0] pend_waddr;
	logic [data_width-1:0]     pend_wdata;
	logic                      pend_hilo_chk;
	logic                      pend_whilo;
	logic [data_width-1:0]     pend_hi;
	logic [data_width-1:0]     pend_lo;
	logic [data_width-1:0]     model_hi;
	logic [data_width-1:0]     model_lo;

	int value_errors = 0;
	int reset_errors = 0;

	aluop_t logic_ops[8] = '{op_and, op_or, op_xor, op_nor, op_lui, op_sll, op_srl, op_sra};
	aluop_t arith_ops[6] = '{op_add, op_addu, op_sub, op_subu, op_slt, op_sltu};

	ex_top uut (
		.clk              (clk),
		.reset_n          (reset_n),
		.alusel           (alusel),
		.aluop            (aluop),
		.reg1_data        (reg1_data),
		.reg2_data        (reg2_data),
		.id_we            (id_we),
		.id_waddr         (id_waddr),
		.ex_we            (ex_we),
		.ex_waddr         (ex_waddr),
		.ex_wdata         (ex_wdata),
		.ex_whilo         (ex_whilo),
		.ex_hi            (ex_hi),
		.ex_lo            (ex_lo),
		.stallreg_from_ex (stallreg_from_ex)
	);

	always #(clk_period / 2) clk = ~clk;

	////////////////////
	// checks
	////////////////////
	task value_error(input string name, input logic [31:0] expected, input logic [31:0] actual);
		value_errors++;
		$display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
	endtask

	a_reset: assert property (@(posedge clk) rst_chk |-> (!ex_we && !ex_whilo &&
		!stallreg_from_ex && ex_waddr == '0 && ex_wdata == '0 && ex_hi == '0 && ex_lo == '0))
		else begin
			reset_errors++;
			$display("outputs were not cleared by reset at %0t", $time);
		end

	a_stall: assert property (@(posedge clk) chk_stall |-> stallreg_from_ex == exp_stall)
		else value_error("stallreg_from_ex", 32'($sampled(exp_stall)),
			32'($sampled(stallreg_from_ex)));
	a_we: assert property (@(posedge clk) chk_wb |-> ex_we == exp_we)
		else value_error("ex_we", 32'($sampled(exp_we)), 32'($sampled(ex_we)));
	a_waddr: assert property (@(posedge clk) chk_wb |-> ex_waddr == exp_waddr)
		else value_error("ex_waddr", 32'($sampled(exp_waddr)), 32'($sampled(ex_waddr)));
	a_wdata: assert property (@(posedge clk) chk_wb |-> ex_wdata == exp_wdata)
		else value_error("ex_wdata", $sampled(exp_wdata), $sampled(ex_wdata));
	a_whilo: assert property (@(posedge clk) chk_hilo |-> ex_whilo == exp_whilo)
		else value_error("ex_whilo", 32'($sampled(exp_whilo)), 32'($sampled(ex_whilo)));
	a_hi: assert property (@(posedge clk) chk_hilo && exp_whilo |-> ex_hi == exp_hi)
		else value_error("ex_hi", $sampled(exp_hi), $sampled(ex_hi));
	a_lo: assert property (@(posedge clk) chk_hilo && exp_whilo |-> ex_lo == exp_lo)
		else value_error("ex_lo", $sampled(exp_lo), $sampled(ex_lo));

	////////////////////
	// reference model
	////////////////////
	function automatic alusel_t group_of(input aluop_t op);
		case (op)
			op_and, op_or, op_xor, op_nor, op_lui: return sel_logic;
			op_sll, op_srl, op_sra:                return sel_shift;
			op_mfhi, op_mflo, op_mthi, op_mtlo:    return sel_move;
			default:                               return sel_arith;
		endcase
	endfunction

	task automatic predict(input alusel_t sel, input aluop_t op, input logic [31:0] a,
		input logic [31:0] b, input logic we, input logic [reg_addr_width-1:0] wa);
		longint      s;
		logic [63:0] p;
		pend_wb_chk   = 1'b1;
		pend_hilo_chk = 1'b1;
		pend_we       = we;
		pend_waddr    = wa;
		pend_wdata    = '0;
		pend_whilo    = 1'b0;
		pend_hi       = '0;
		pend_lo       = '0;
		if (sel != sel_nop) begin
			case (op)
				op_and:  pend_wdata = a & b;
				op_or:   pend_wdata = a | b;
				op_xor:  pend_wdata = a ^ b;
				op_nor:  pend_wdata = ~(a | b);
				op_lui:  pend_wdata = {b[15:0], 16'h0000};
				op_sll:  pend_wdata = b << a[4:0];
				op_srl:  pend_wdata = b >> a[4:0];
				op_sra:  pend_wdata = $signed(b) >>> a[4:0];
				op_addu: pend_wdata = a + b;
				op_subu: pend_wdata = a - b;
				op_slt:  pend_wdata = {31'b0, $signed(a) < $signed(b)};
				op_sltu: pend_wdata = {31'b0, a < b};
				op_mfhi: pend_wdata = model_hi;
				op_mflo: pend_wdata = model_lo;
				op_add, op_sub: begin
					// result outside the signed 32-bit range drops the write
					s = (op == op_add) ? longint'($signed(a)) + longint'($signed(b)) :
						longint'($signed(a)) - longint'($signed(b));
					pend_wdata = s[31:0];
					pend_we    = we && (s <= smax) && (s >= smin);
				end
				op_mult, op_multu: begin
					if (op == op_mult) begin
						p = longint'($signed(a)) * longint'($signed(b));
					end else begin
						p = {32'b0, a} * {32'b0, b};
					end
					pend_wb_chk = 1'b0;
					pend_whilo  = 1'b1;
					pend_hi     = p[63:32];
					pend_lo     = p[31:0];
				end
				op_mthi, op_mtlo: begin
					pend_wb_chk = 1'b0;
					pend_whilo  = 1'b1;
					pend_hi     = (op == op_mthi) ? a : model_hi;
					pend_lo     = (op == op_mtlo) ? a : model_lo;
				end
				default: ;
			endcase
		end
		if (pend_whilo) begin
			model_hi = pend_hi;
			model_lo = pend_lo;
		end
	endtask

	////////////////////
	// stimulus
	////////////////////
	task automatic promote();
		chk_wb    <= pend_wb_chk;
		exp_we    <= pend_we;
		exp_waddr <= pend_waddr;
		exp_wdata <= pend_wdata;
		chk_hilo  <= pend_hilo_chk;
		exp_whilo <= pend_whilo;
		exp_hi    <= pend_hi;
		exp_lo    <= pend_lo;
	endtask

	task automatic drive(input alusel_t sel, input aluop_t op, input logic [31:0] a,
		input logic [31:0] b, input logic we, input logic [reg_addr_width-1:0] wa);
		alusel    <= sel;
		aluop     <= op;
		reg1_data <= a;
		reg2_data <= b;
		id_we     <= we;
		id_waddr  <= wa;
	endtask

	// one op per cycle while the previous result is checked
	task automatic send(input alusel_t sel, input aluop_t op, input logic [31:0] a,
		input logic [31:0] b, input logic we, input logic [reg_addr_width-1:0] wa);
		@(posedge clk);
		promote();
		drive(sel, op, a, b, we, wa);
		predict(sel, op, a, b, we, wa);
	endtask

	task automatic issue(input aluop_t op, input logic [31:0] a, input logic [31:0] b);
		send(group_of(op), op, a, b, 1'($urandom), reg_addr_width'($urandom));
	endtask

	task automatic set_bubble();
		predict(sel_nop, op_sll, '0, '0, 1'b0, '0);
	endtask

	task automatic run_div(input logic sgn, input logic [31:0] a, input logic [31:0] b);
		logic [31:0] q;
		logic [31:0] r;
		if (sgn) begin
			q = $signed(a) / $signed(b);
			r = $signed(a) % $signed(b);
		end else begin
			q = a / b;
			r = a % b;
		end
		@(posedge clk);
		promote();
		drive(sel_arith, sgn ? op_div : op_divu, a, b, 1'b0, '0);
		set_bubble();
		pend_wb_chk = 1'b0;
		// stall rises after the edge that takes the divide
		@(posedge clk);
		promote();
		exp_stall <= 1'b1;
		set_bubble();
		repeat (div_steps - 1) begin
			@(posedge clk);
			promote();
		end
		// last step done so the inputs are released
		@(posedge clk);
		promote();
		exp_stall <= 1'b0;
		drive(sel_nop, op_sll, '0, '0, 1'b0, '0);
		set_bubble();
		pend_whilo = 1'b1;
		pend_hi    = r;
		pend_lo    = q;
		model_hi   = r;
		model_lo   = q;
	endtask

	initial begin
		#(timeout);
		$display("watchdog expired before the tests completed");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		void'($urandom(seed));
		reset_n   = 1'b0;
		alusel    = sel_nop;
		aluop     = op_sll;
		reg1_data = '0;
		reg2_data = '0;
		id_we     = 1'b0;
		id_waddr  = '0;
		rst_chk   = 1'b0;
		chk_stall = 1'b0;
		exp_stall = 1'b0;
		model_hi  = '0;
		model_lo  = '0;
		pend_wb_chk   = 1'b0;
		pend_hilo_chk = 1'b0;
		promote();

		@(posedge clk);
		rst_chk <= 1'b1;
		repeat (reset_cycles - 1) @(posedge clk);
		reset_n <= 1'b1;
		repeat (2) @(posedge clk);
		rst_chk   <= 1'b0;
		chk_stall <= 1'b1;

		// logic and shift
		for (int i = 0; i < n_logic; i++) begin
			issue(logic_ops[$urandom % 8], $urandom, $urandom);
		end
		issue(op_sra, 32'd7, 32'h8000_1234);
		issue(op_sra, 32'd31, 32'hf000_0000);

		// add, sub and compare
		for (int i = 0; i < n_arith; i++) begin
			issue(arith_ops[$urandom % 6], $urandom, $urandom);
		end
		send(sel_arith, op_add, 32'h7fff_ffff, 32'h0000_0001, 1'b1, 5'd4);
		send(sel_arith, op_add, 32'h8000_0000, 32'hffff_ffff, 1'b1, 5'd5);
		send(sel_arith, op_sub, 32'h8000_0000, 32'h0000_0001, 1'b1, 5'd6);
		send(sel_arith, op_sub, 32'h7fff_ffff, 32'hffff_ffff, 1'b1, 5'd7);
		send(sel_arith, op_addu, 32'h7fff_ffff, 32'h0000_0001, 1'b1, 5'd8);
		send(sel_arith, op_subu, 32'h8000_0000, 32'h0000_0001, 1'b1, 5'd9);
		send(sel_arith, op_slt, 32'hffff_ffff, 32'h0000_0001, 1'b1, 5'd10);
		send(sel_arith, op_sltu, 32'hffff_ffff, 32'h0000_0001, 1'b1, 5'd11);

		// multiply and hilo moves
		for (int i = 0; i < n_mul; i++) begin
			issue((i % 2) ? op_multu : op_mult, $urandom, $urandom);
			issue(op_mfhi, $urandom, $urandom);
			issue(op_mflo, $urandom, $urandom);
			issue(op_mthi, $urandom, $urandom);
			issue((i % 2) ? op_mflo : op_mfhi, $urandom, $urandom);
		end
		issue(op_mtlo, 32'hcafe_f00d, '0);
		issue(op_mflo, '0, '0);

		// divides with non-zero divisors
		for (int i = 0; i < n_div; i++) begin
			a = $urandom;
			b = (i % 2) ? $urandom : ($urandom % 1000) + 1;
			if (i % 4 == 0) begin
				b = -b;
			end
			if (b == '0) begin
				b = 32'd1;
			end
			if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
				b = 32'd3;
			end
			run_div(i % 3 != 2, a, b);
			issue(op_mflo, '0, '0);
		end

		send(sel_nop, op_sll, '0, '0, 1'b0, '0);
		@(posedge clk);
		promote();
		pend_wb_chk   = 1'b0;
		pend_hilo_chk = 1'b0;
		@(posedge clk);
		promote();
		@(negedge clk);

		$display("value errors: %0d, reset errors: %0d", value_errors, reset_errors);
		if (value_errors + reset_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== list.f ====
source/ex_pkg.sv
source/alu_comb.sv
source/div_ctrl.sv
source/div_counter.sv
source/div_datapath.sv
source/ex_stage_reg.sv
source/hilo_file.sv
source/ex_top.sv
verification/ex_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - files:
      - source/ex_pkg.sv
      - source/alu_comb.sv
      - source/div_ctrl.sv
      - source/div_counter.sv
      - source/div_datapath.sv
      - source/ex_stage_reg.sv
      - source/hilo_file.sv
      - source/ex_top.sv
  - target: test
    files:
      - verification/ex_tb.sv
